/* common/rsa_pkg.sv */
package rsa_pkg;

    // operand width for n, d, the ciphertext and the result
    localparam int rsa_width = 256;

    // serial-port register map, word addresses on avm_address
    localparam logic [4:0] rx_base     = 5'd0;
    localparam logic [4:0] tx_base     = 5'd4;
    localparam logic [4:0] status_base = 5'd8;

    // status register flags
    localparam int rx_ok_bit = 7;  // a received byte is waiting
    localparam int tx_ok_bit = 6;  // transmitter can take a byte

    // bytes per operand on the way in, and bytes sent per result
    localparam int key_bytes = 32;
    localparam int out_bytes = 31;

    // the top result byte is dropped, so sending starts below it
    typedef enum logic [2:0] {
        read_ready,   // poll status before a receive read
        get_n,
        get_d,
        get_data,
        wait_calc,
        write_ready,  // poll status before a transmit write
        send_data
    } wrap_state_t;

    typedef enum logic [1:0] {
        idle,
        prep,  // pre-multiplication into the Montgomery domain
        mont,  // one multiply and square round
        done
    } core_state_t;

endpackage

/* common/rsa_core_if.sv */
`timescale 1ns/1ps

interface rsa_core_if import rsa_pkg::*; ();

    logic                 start;     // one-cycle pulse from the wrapper
    logic [rsa_width-1:0] a;         // ciphertext
    logic [rsa_width-1:0] d;         // private exponent
    logic [rsa_width-1:0] n;         // modulus
    logic [rsa_width-1:0] result;
    logic                 finished;  // one-cycle pulse, result valid with it

    // a, d and n are held by the wrapper from start until finished
    modport wrapper (
        output start, a, d, n,
        input  result, finished
    );

    modport core (
        input  start, a, d, n,
        output result, finished
    );

endinterface

/* common/rsa_arith_if.sv */
`timescale 1ns/1ps

// Montgomery multiplier link, a times b times 2^-256 mod n
interface mont_if import rsa_pkg::*; ();

    logic                 start;
    logic [rsa_width-1:0] a;
    logic [rsa_width-1:0] b;
    logic [rsa_width-1:0] n;
    logic [rsa_width-1:0] result;
    logic                 done;

    modport master (
        output start, a, b, n,
        input  result, done
    );

    modport unit (
        input  start, a, b, n,
        output result, done
    );

endinterface

// pre-multiplier link, a times 2^256 mod n
interface modprod_if import rsa_pkg::*; ();

    logic                 start;
    logic [rsa_width-1:0] a;
    logic [rsa_width-1:0] n;
    logic [rsa_width-1:0] result;
    logic                 done;

    modport master (
        output start, a, n,
        input  result, done
    );

    modport unit (
        input  start, a, n,
        output result, done
    );

endinterface

/* src/rsa_wrapper.sv */
`timescale 1ns/1ps

module rsa_wrapper import rsa_pkg::*; (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest,
    rsa_core_if.wrapper core
);

    wrap_state_t          state_r, state_w;
    logic [6:0]           cnt_r, cnt_w;  // bytes taken in this block, or bytes sent
    logic                 have_key_r, have_key_w;
    logic                 start_r, start_w;
    logic [4:0]           address_r, address_w;
    logic                 read_r, read_w;
    logic                 write_r, write_w;
    logic [rsa_width-1:0] n_r, n_w;
    logic [rsa_width-1:0] d_r, d_w;
    logic [rsa_width-1:0] a_r, a_w;
    logic [rsa_width-1:0] res_r, res_w;
    logic [7:0]           rx_byte;
    logic                 last_byte;

    assign rx_byte = avm_readdata[7:0];

    // with a stored key only the ciphertext comes in
    assign last_byte = have_key_r ? (cnt_r == 7'(key_bytes - 1))
                                  : (cnt_r == 7'(3 * key_bytes - 1));

    assign avm_address   = address_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = {24'b0, res_r[rsa_width-9 -: 8]};  // byte 30 first

    assign core.start = start_r;
    assign core.a     = a_r;
    assign core.d     = d_r;
    assign core.n     = n_r;

    always_comb begin
        state_w    = state_r;
        cnt_w      = cnt_r;
        have_key_w = have_key_r;
        start_w    = 1'b0;
        address_w  = address_r;
        read_w     = read_r;
        write_w    = write_r;
        n_w        = n_r;
        d_w        = d_r;
        a_w        = a_r;
        res_w      = res_r;

        case (state_r)
            read_ready: begin
                if (!avm_waitrequest && avm_readdata[rx_ok_bit]) begin
                    address_w = rx_base;
                    if (have_key_r || cnt_r >= 7'(2 * key_bytes))
                        state_w = get_data;
                    else if (cnt_r >= 7'(key_bytes))
                        state_w = get_d;
                    else
                        state_w = get_n;
                end
            end
            get_n, get_d, get_data: begin
                if (!avm_waitrequest) begin
                    // most significant byte arrives first
                    if (state_r == get_n)
                        n_w = {n_r[rsa_width-9:0], rx_byte};
                    else if (state_r == get_d)
                        d_w = {d_r[rsa_width-9:0], rx_byte};
                    else
                        a_w = {a_r[rsa_width-9:0], rx_byte};

                    if (state_r == get_data && last_byte) begin
                        start_w = 1'b1;
                        read_w  = 1'b0;
                        cnt_w   = '0;
                        state_w = wait_calc;
                    end else begin
                        cnt_w     = cnt_r + 7'd1;
                        address_w = status_base;
                        state_w   = read_ready;
                    end
                end
            end
            wait_calc: begin
                if (core.finished) begin
                    res_w     = core.result;
                    read_w    = 1'b1;
                    address_w = status_base;
                    state_w   = write_ready;
                end
            end
            write_ready: begin
                if (!avm_waitrequest && avm_readdata[tx_ok_bit]) begin
                    read_w    = 1'b0;
                    write_w   = 1'b1;
                    address_w = tx_base;
                    state_w   = send_data;
                end
            end
            send_data: begin
                if (!avm_waitrequest) begin
                    write_w   = 1'b0;
                    read_w    = 1'b1;
                    address_w = status_base;
                    if (cnt_r == 7'(out_bytes - 1)) begin
                        cnt_w      = '0;
                        have_key_w = 1'b1;
                        state_w    = read_ready;
                    end else begin
                        cnt_w   = cnt_r + 7'd1;
                        res_w   = res_r << 8;
                        state_w = write_ready;
                    end
                end
            end
            default: state_w = read_ready;
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r    <= read_ready;
            cnt_r      <= '0;
            have_key_r <= 1'b0;
            start_r    <= 1'b0;
            address_r  <= status_base;
            read_r     <= 1'b1;  // polling starts right out of reset
            write_r    <= 1'b0;
        end else begin
            state_r    <= state_w;
            cnt_r      <= cnt_w;
            have_key_r <= have_key_w;
            start_r    <= start_w;
            address_r  <= address_w;
            read_r     <= read_w;
            write_r    <= write_w;
        end
    end

    always_ff @(posedge avm_clk) begin
        n_r   <= n_w;
        d_r   <= d_w;
        a_r   <= a_w;
        res_r <= res_w;
    end

endmodule

/* rsa_core/rsa_montgomery.sv */
`timescale 1ns/1ps

module rsa_montgomery import rsa_pkg::*; (
    input  logic avm_clk,
    input  logic avm_rst,
    mont_if.unit port
);

    logic [rsa_width+1:0] acc_r;  // stays below 2n between steps
    logic [8:0]           cnt_r;
    logic                 run_r;
    logic                 done_r;
    logic [rsa_width+1:0] step_val;
    logic [rsa_width+1:0] final_val;

    always_comb begin
        logic [rsa_width+1:0] sum;
        logic [rsa_width+1:0] odd_fix;
        sum      = acc_r + (port.a[cnt_r[7:0]] ? {2'b0, port.b} : '0);
        odd_fix  = sum + (sum[0] ? {2'b0, port.n} : '0);  // n is odd, so this clears bit 0
        step_val = odd_fix >> 1;
        final_val = (acc_r >= {2'b0, port.n}) ? acc_r - {2'b0, port.n} : acc_r;
    end

    assign port.result = acc_r[rsa_width-1:0];
    assign port.done   = done_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            cnt_r  <= '0;
            run_r  <= 1'b0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (port.start) begin
                cnt_r <= '0;
                run_r <= 1'b1;
            end else if (run_r) begin
                if (cnt_r == 9'(rsa_width)) begin
                    run_r  <= 1'b0;  // final subtract happens on this edge
                    done_r <= 1'b1;
                end else begin
                    cnt_r <= cnt_r + 9'd1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (port.start)
            acc_r <= '0;
        else if (run_r)
            acc_r <= (cnt_r == 9'(rsa_width)) ? final_val : step_val;
    end

endmodule

/* rsa_core/rsa_modprod.sv */
`timescale 1ns/1ps

module rsa_modprod import rsa_pkg::*; (
    input  logic   avm_clk,
    input  logic   avm_rst,
    modprod_if.unit port
);

    logic [rsa_width+1:0] val_r;  // always reduced below n after a step
    logic [7:0]           cnt_r;
    logic                 run_r;
    logic                 done_r;
    logic [rsa_width+1:0] dbl;
    logic [rsa_width+1:0] next_val;

    assign dbl      = {val_r[rsa_width:0], 1'b0};
    assign next_val = (dbl >= {2'b0, port.n}) ? dbl - {2'b0, port.n} : dbl;

    assign port.result = val_r[rsa_width-1:0];
    assign port.done   = done_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            cnt_r  <= '0;
            run_r  <= 1'b0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (port.start) begin
                cnt_r <= '0;
                run_r <= 1'b1;
            end else if (run_r) begin
                cnt_r <= cnt_r + 8'd1;
                if (cnt_r == 8'(rsa_width - 1)) begin
                    run_r  <= 1'b0;
                    done_r <= 1'b1;  // result is valid from the next cycle
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (port.start)
            val_r <= {2'b0, port.a};
        else if (run_r)
            val_r <= next_val;
    end

endmodule

/* rsa_core/rsa_core.sv */
`timescale 1ns/1ps

module rsa_core import rsa_pkg::*; (
    input  logic      avm_clk,
    input  logic      avm_rst,
    rsa_core_if.core  wrap,
    modprod_if.master prep,
    mont_if.master    mul,
    mont_if.master    sqr
);

    core_state_t          state_r;
    logic [7:0]           bit_r;      // exponent bit of the current round
    logic                 restart_r;  // starts every round after the first
    logic [rsa_width-1:0] prod_r;     // running product, plain domain
    logic [rsa_width-1:0] sqr_r;      // a^(2^i) times 2^256 mod n
    logic [rsa_width-1:0] sqr_src;
    logic                 go;
    logic                 round_done;

    assign prep.start = (state_r == idle) && wrap.start;
    assign prep.a     = wrap.a;
    assign prep.n     = wrap.n;

    // round 0 starts in the same cycle the pre-multiplier finishes
    assign sqr_src    = (state_r == rsa_pkg::prep) ? prep.result : sqr_r;
    assign go         = ((state_r == rsa_pkg::prep) && prep.done) || restart_r;
    assign round_done = (state_r == mont) && mul.done && sqr.done;

    assign mul.start = go;
    assign mul.a     = prod_r;
    assign mul.b     = sqr_src;
    assign mul.n     = wrap.n;

    assign sqr.start = go;
    assign sqr.a     = sqr_src;
    assign sqr.b     = sqr_src;
    assign sqr.n     = wrap.n;

    assign wrap.result   = prod_r;
    assign wrap.finished = (state_r == rsa_pkg::done);

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r   <= idle;
            bit_r     <= '0;
            restart_r <= 1'b0;
        end else begin
            restart_r <= 1'b0;
            case (state_r)
                idle: if (wrap.start) state_r <= rsa_pkg::prep;
                rsa_pkg::prep: begin
                    if (prep.done) begin
                        bit_r   <= '0;
                        state_r <= mont;
                    end
                end
                mont: begin
                    if (round_done) begin
                        if (bit_r == 8'(rsa_width - 1)) begin
                            state_r <= rsa_pkg::done;
                        end else begin
                            bit_r     <= bit_r + 8'd1;
                            restart_r <= 1'b1;
                        end
                    end
                end
                default: state_r <= idle;  // finished pulses for one cycle
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state_r == idle && wrap.start)
            prod_r <= rsa_width'(1);
        if (state_r == rsa_pkg::prep && prep.done)
            sqr_r <= prep.result;
        if (round_done) begin
            sqr_r <= sqr.result;
            if (wrap.d[bit_r])
                prod_r <= mul.result;  // multiply only where the exponent bit is set
        end
    end

endmodule

/* src/rsa_top.sv */
`timescale 1ns/1ps

module rsa_top (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);

    rsa_core_if u_core_if ();
    modprod_if  u_prep_if ();
    mont_if     u_mul_if ();
    mont_if     u_sqr_if ();

    rsa_wrapper u_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .core            (u_core_if.wrapper)
    );

    rsa_core u_core (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .wrap    (u_core_if.core),
        .prep    (u_prep_if.master),
        .mul     (u_mul_if.master),
        .sqr     (u_sqr_if.master)
    );

    rsa_modprod    u_prep (.avm_clk(avm_clk), .avm_rst(avm_rst), .port(u_prep_if.unit));
    rsa_montgomery u_mul  (.avm_clk(avm_clk), .avm_rst(avm_rst), .port(u_mul_if.unit));
    rsa_montgomery u_sqr  (.avm_clk(avm_clk), .avm_rst(avm_rst), .port(u_sqr_if.unit));

endmodule

/* sim/rsa_asserts.sv */
`timescale 1ns/1ps

module rsa_asserts import rsa_pkg::*; (
    input logic        avm_clk,
    input logic        avm_rst,
    input logic [4:0]  avm_address,
    input logic        avm_read,
    input logic [31:0] avm_readdata,
    input logic        avm_write,
    input logic [31:0] avm_writedata,
    input logic        avm_waitrequest
);

    int unsigned fail_count = 0;  // read by the testbench
    logic        first_xfer_r;    // an edge with waitrequest low has been seen
    logic [31:0] last_status_r;   // value of the last completed status read

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            first_xfer_r  <= 1'b0;
            last_status_r <= '0;
        end else begin
            if (!avm_waitrequest)
                first_xfer_r <= 1'b1;
            if (avm_read && !avm_waitrequest && avm_address == status_base)
                last_status_r <= avm_readdata;
        end
    end

    reset_poll: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !first_xfer_r |-> (avm_read && !avm_write && avm_address == status_base))
        else begin
            fail_count++;
            $error("bus did not start with a status poll after reset");
        end

    one_strobe: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else begin
            fail_count++;
            $error("read and write were asserted together");
        end

    // only the three serial-port registers exist
    legal_address: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_address == rx_base || avm_address == tx_base || avm_address == status_base))
        else begin
            fail_count++;
            $error("address outside the serial-port register map");
        end

    hold_on_wait: assert property (@(posedge avm_clk) disable iff (avm_rst)
        ((avm_read || avm_write) && avm_waitrequest) |=>
            ($stable(avm_read) && $stable(avm_write) && $stable(avm_address)
             && (!avm_write || $stable(avm_writedata))))
        else begin
            fail_count++;
            $error("request changed while waitrequest was high");
        end

    rx_after_status: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read && avm_address == rx_base) |-> last_status_r[rx_ok_bit])
        else begin
            fail_count++;
            $error("receive read without a waiting byte in the last status");
        end

    tx_after_status: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_write && avm_address == tx_base) |-> last_status_r[tx_ok_bit])
        else begin
            fail_count++;
            $error("transmit write without transmit ready in the last status");
        end

endmodule

bind rsa_top rsa_asserts u_asserts (
    .avm_clk         (avm_clk),
    .avm_rst         (avm_rst),
    .avm_address     (avm_address),
    .avm_read        (avm_read),
    .avm_readdata    (avm_readdata),
    .avm_write       (avm_write),
    .avm_writedata   (avm_writedata),
    .avm_waitrequest (avm_waitrequest)
);

/* sim/tb_rsa.sv */
`timescale 1ns/1ps

module tb_rsa import rsa_pkg::*; ();

    localparam logic [rsa_width-1:0] key_n =
        256'hc7f3_1a2b_9e4d_6c85_0f17_e2a9_3b5d_7c41_88e2_5f9a_0d36_b4c7_1e8f_a253_6d09_c3e7;
    localparam logic [rsa_width-1:0] key_d =
        256'h5b21_0e7f_c4a8_3d96_71b2_e05c_9a4f_2d83_16c7_f9e0_4b3a_8d25_e761_0fc9_3a84_b5d1;
    localparam logic [rsa_width-1:0] cipher_0 =
        256'h3e9a_7c12_5fd0_b846_2a9e_13c7_f05b_6d28_91e4_7ab3_c06d_5f19_28e7_b4a0_d35c_9e62;
    localparam logic [rsa_width-1:0] cipher_1 =
        256'h8a14_f6d3_2c70_95eb_4d1a_c8f2_67b0_3e59_a2d6_1f84_c79b_05e3_d6a1_7f28_4bc0_e193;

    // pre-multiply plus 256 rounds of 259 cycles each
    localparam int core_cycles     = (rsa_width + 1) + rsa_width * (rsa_width + 3);
    localparam int watchdog_cycles = 2 * core_cycles + (4 * key_bytes + 2 * out_bytes) * 64;

    logic        avm_clk;
    logic        avm_rst;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest;

    logic [31:0] lfsr_state = 32'h7ed4c5f5;
    logic [7:0]  rx_q[$];                   // bytes the serial port still has to deliver
    logic [7:0]  exp_bytes [2*out_bytes];
    int          rx_taken = 0;
    int          tx_count = 0;
    int          reset_cycles = 0;

    rsa_top u_dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #50 avm_clk = ~avm_clk;

    function automatic logic rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'ha300_0000;
        return out;
    endfunction

    // plain square-and-multiply on 512-bit intermediates
    function automatic logic [rsa_width-1:0] mod_pow(input logic [rsa_width-1:0] base,
                                                    input logic [rsa_width-1:0] exponent,
                                                    input logic [rsa_width-1:0] modulus);
        logic [2*rsa_width-1:0] acc;
        logic [2*rsa_width-1:0] sq;
        logic [2*rsa_width-1:0] m;
        acc = 1;
        sq  = {{rsa_width{1'b0}}, base};
        m   = {{rsa_width{1'b0}}, modulus};
        for (int i = 0; i < rsa_width; i++) begin
            if (exponent[i])
                acc = (acc * sq) % m;
            sq = (sq * sq) % m;
        end
        return acc[rsa_width-1:0];
    endfunction

    task automatic queue_operand(input logic [rsa_width-1:0] value);
        for (int k = key_bytes - 1; k >= 0; k--)
            rx_q.push_back(value[8*k +: 8]);  // most significant byte first
    endtask

    task automatic expect_block(input int blk, input logic [rsa_width-1:0] value);
        for (int j = 0; j < out_bytes; j++)
            exp_bytes[blk * out_bytes + j] = value[8*(out_bytes - 1 - j) +: 8];
    endtask

    task automatic check_tx_byte(input logic [31:0] got);
        int          consumed;
        logic [31:0] expected;
        consumed = (tx_count < out_bytes) ? 3 * key_bytes : 4 * key_bytes;
        assert (tx_count < 2 * out_bytes) else begin
            $display("transmit write at %0t ns after both blocks were sent", $time);
            $display("=== FAIL ===");
            $fatal(1);
        end
        assert (rx_taken == consumed) else begin
            $display("block sent at %0t ns after %0d received bytes instead of %0d",
                     $time, rx_taken, consumed);
            $display("=== FAIL ===");
            $fatal(1);
        end
        expected = {24'b0, exp_bytes[tx_count]};  // the byte sits in the low lane, zeros above
        assert (got == expected) else begin
            $display("error: %0t ns avm_writedata byte %0d got %08h expected %08h",
                     $time, tx_count, got, expected);
            $display("=== FAIL ===");
            $fatal(1);
        end
        tx_count++;
    endtask

    // serial-port model, answers the transfer that completes on the next edge
    task automatic serve_bus();
        logic busy;
        logic rx_bit;
        logic tx_bit;
        busy = rand_bit();
        avm_waitrequest = busy;
        avm_readdata    = '0;
        if (!busy && avm_read) begin
            if (avm_address == status_base) begin
                rx_bit = rand_bit();
                tx_bit = rand_bit();
                avm_readdata[rx_ok_bit] = rx_bit && (rx_q.size() > 0);
                avm_readdata[tx_ok_bit] = tx_bit;
            end else if (avm_address == rx_base && rx_q.size() > 0) begin
                avm_readdata = {24'b0, rx_q.pop_front()};
                rx_taken++;
            end
        end
        if (!busy && avm_write && avm_address == tx_base)
            check_tx_byte(avm_writedata);
    endtask

    always @(posedge avm_clk) begin
        #1;
        if (reset_cycles < 4) begin
            reset_cycles++;
            avm_rst = (reset_cycles < 4);
        end else begin
            serve_bus();
        end
    end

    always @(negedge avm_clk) begin
        if (u_dut.u_asserts.fail_count != 0) begin
            $display("bus protocol assertion failed at %0t ns", $time);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge avm_clk);
        $display("timeout: the two blocks were not sent within %0d cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        avm_clk         = 1'b0;
        avm_rst         = 1'b1;
        avm_waitrequest = 1'b1;
        avm_readdata    = '0;
        queue_operand(key_n);
        queue_operand(key_d);
        queue_operand(cipher_0);
        queue_operand(cipher_1);  // second block reuses the stored key
        expect_block(0, mod_pow(cipher_0, key_d, key_n));
        expect_block(1, mod_pow(cipher_1, key_d, key_n));

        while (tx_count < 2 * out_bytes)
            @(posedge avm_clk);
        repeat (4) @(posedge avm_clk);

        if (u_dut.u_asserts.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("bus protocol assertion failed before the end of the run");
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule

/* build.f */
common/rsa_pkg.sv
common/rsa_core_if.sv
common/rsa_arith_if.sv
src/rsa_wrapper.sv
rsa_core/rsa_montgomery.sv
rsa_core/rsa_modprod.sv
rsa_core/rsa_core.sv
src/rsa_top.sv
sim/rsa_asserts.sv
sim/tb_rsa.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rsa
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
